// ==== source/core_consts.svh ====
// Core constants
// Widths, queue depth and PC behaviour for the RV32I core

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data and address width
`define CORE_XLEN 32

// Integer register file
`define CORE_NUM_REGS 32
`define CORE_REG_ADDR_W 5

// Instruction queue entries
`define CORE_QUEUE_DEPTH 4

// Program counter
`define CORE_RESET_PC 32'h0000_0000
`define CORE_PC_STEP 32'd4

`endif

// ==== source/core_pkg.sv ====
// Core package
// Opcode and ALU enums, and the packets passed between core blocks

`include "core_consts.svh"

package core_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // Fetched word with its address
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } fetch_packet_t;

    typedef struct packed {
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0] imm;
        logic use_imm;
        alu_op_t alu_op;
        logic writes_rd;
    } decoded_t;

    // One retired instruction
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic wr_en;
        logic [`CORE_XLEN-1:0] value;
    } retire_trace_t;

endpackage

// ==== source/register_file.sv ====
// Register file
// 32 integer registers, two asynchronous reads and one synchronous write

`include "core_consts.svh"

module register_file
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        input logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
        input logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
        output logic [`CORE_XLEN-1:0] rs1_data,
        output logic [`CORE_XLEN-1:0] rs2_data,

        input logic write_en,
        input logic [`CORE_REG_ADDR_W-1:0] write_addr,
        input logic [`CORE_XLEN-1:0] write_data
    );

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (write_en && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/alu_unit.sv ====
// Integer ALU
// Add, subtract, logic, compares and shifts for the RV32I ALU group

`include "core_consts.svh"

module alu_unit
    import core_pkg::*;
    (
        input alu_op_t alu_op,
        input logic [`CORE_XLEN-1:0] a,
        input logic [`CORE_XLEN-1:0] b,
        output logic [`CORE_XLEN-1:0] result
    );

    logic [4:0] shamt;
    logic signed_lt;
    logic unsigned_lt;

    assign shamt = b[4:0];
    assign signed_lt = ($signed(a) < $signed(b));
    assign unsigned_lt = (a < b);

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {{(`CORE_XLEN-1){1'b0}}, signed_lt};
            ALU_SLTU:   result = {{(`CORE_XLEN-1){1'b0}}, unsigned_lt};
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            // LUI
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== source/decode_unit.sv ====
// Decode unit
// Splits an RV32I word into register addresses, immediate and ALU operation,
// and flags whether the instruction writes rd

`include "core_consts.svh"

module decode_unit
    import core_pkg::*;
    (
        input logic [`CORE_XLEN-1:0] instr,
        output decoded_t decoded
    );

    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic alt;
    alu_op_t op_sel;
    logic supported;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // SUB and SRA variant
    assign alt = (funct7 == 7'b0100000);

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000: op_sel = ALU_ADD;
            3'b001: op_sel = ALU_SLL;
            3'b010: op_sel = ALU_SLT;
            3'b011: op_sel = ALU_SLTU;
            3'b100: op_sel = ALU_XOR;
            3'b101: op_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110: op_sel = ALU_OR;
            default: op_sel = ALU_AND;
        endcase
    end

    always_comb begin
        decoded.rs1 = instr[19:15];
        decoded.rs2 = instr[24:20];
        decoded.rd = instr[11:7];
        decoded.imm = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
        decoded.use_imm = 1'b1;
        decoded.alu_op = op_sel;
        supported = 1'b0;

        case (opcode)
            OPC_OP: begin
                decoded.use_imm = 1'b0;
                if (funct3 == 3'b000 && alt)
                    decoded.alu_op = ALU_SUB;
                supported = (funct7 == 7'b0) ||
                            (alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                // Shift immediates carry a funct7 field
                if (funct3 == 3'b001)
                    supported = (funct7 == 7'b0);
                else if (funct3 == 3'b101)
                    supported = (funct7 == 7'b0) || alt;
                else
                    supported = 1'b1;
            end
            OPC_LUI: begin
                decoded.imm = {instr[31:12], 12'b0};
                decoded.alu_op = ALU_PASS_B;
                supported = 1'b1;
            end
            default: supported = 1'b0;
        endcase

        // x0 writes are dropped here
        decoded.writes_rd = supported && (decoded.rd != '0);
    end

endmodule

// ==== source/fetch_unit.sv ====
// Fetch unit
// Steps the PC, requests words from the local instruction memory
// and pushes each returned word, tagged with its address, into the queue

`include "core_consts.svh"

module fetch_unit
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        input logic has_room,

        output logic instr_en,
        output logic [`CORE_XLEN-1:0] instr_addr,
        input logic [`CORE_XLEN-1:0] instr_data,

        output logic push,
        output fetch_packet_t push_data
    );

    logic [`CORE_XLEN-1:0] pc;
    logic running;
    logic req_pending;
    logic [`CORE_XLEN-1:0] req_addr;

    //////////////////////////////////////////////////
    // Request side
    // Fetch starts on the first cycle out of reset
    assign instr_en = running & has_room;
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pc <= `CORE_RESET_PC;
            req_pending <= 1'b0;
        end else begin
            running <= 1'b1;
            req_pending <= instr_en;
            if (instr_en)
                pc <= pc + `CORE_PC_STEP;
        end
    end

    // Address of the request in flight
    always_ff @(posedge clk) begin
        if (instr_en)
            req_addr <= pc;
    end

    //////////////////////////////////////////////////
    // Return side
    // Memory answers one cycle after the request
    assign push = req_pending;
    assign push_data.pc = req_addr;
    assign push_data.instr = instr_data;

endmodule

// ==== source/instruction_queue.sv ====
// Instruction queue
// Circular FIFO of fetch packets between fetch and execute

`include "core_consts.svh"

module instruction_queue
    import core_pkg::*;
    #(
        parameter int DEPTH = `CORE_QUEUE_DEPTH
    )
    (
        input logic clk,
        input logic rst,

        input logic push,
        input fetch_packet_t push_data,
        output logic has_room,

        input logic pop,
        output logic not_empty,
        output fetch_packet_t head
    );

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_packet_t entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= push_data;
    end

    // Two free slots, one may already be requested
    assign has_room = (count <= CNT_W'(DEPTH - 2));
    assign not_empty = (count != '0);
    assign head = entries[rd_ptr];

endmodule

// ==== source/execute_unit.sv ====
// Execute unit
// Pops one instruction, decodes it, reads operands, runs the ALU,
// writes rd and presents the retired instruction on the trace port

`include "core_consts.svh"

module execute_unit
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        input logic not_empty,
        input fetch_packet_t head,
        output logic pop,

        output logic trace_valid,
        output retire_trace_t trace,
        input logic trace_ready
    );

    decoded_t dec;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic [`CORE_XLEN-1:0] operand_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic trace_free;
    logic rd_write;

    //////////////////////////////////////////////////
    // Issue
    // Only pop when the trace slot can take the result
    assign trace_free = ~trace_valid | trace_ready;
    assign pop = not_empty & trace_free;
    assign rd_write = pop & dec.writes_rd;

    decode_unit decode_block (
        .instr (head.instr),
        .decoded (dec)
    );

    register_file register_file_block (
        .clk (clk),
        .rst (rst),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .write_en (rd_write),
        .write_addr (dec.rd),
        .write_data (alu_result)
    );

    assign operand_b = dec.use_imm ? dec.imm : rs2_data;

    alu_unit alu_block (
        .alu_op (dec.alu_op),
        .a (rs1_data),
        .b (operand_b),
        .result (alu_result)
    );

    //////////////////////////////////////////////////
    // Retire trace
    always_ff @(posedge clk) begin
        if (rst)
            trace_valid <= 1'b0;
        else if (pop)
            trace_valid <= 1'b1;
        else if (trace_ready)
            trace_valid <= 1'b0;
    end

    // Held while the port is stalled
    always_ff @(posedge clk) begin
        if (pop) begin
            trace.pc <= head.pc;
            trace.instr <= head.instr;
            trace.rd <= dec.rd;
            trace.wr_en <= dec.writes_rd;
            trace.value <= dec.writes_rd ? alu_result : '0;
        end
    end

endmodule

// ==== source/mini_core.sv ====
// Mini RV32I core
// Fetch, instruction queue and execute joined between the
// instruction memory port and the retire trace port

`include "core_consts.svh"

module mini_core
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        output logic instr_en,
        output logic [`CORE_XLEN-1:0] instr_addr,
        input logic [`CORE_XLEN-1:0] instr_data,

        output logic trace_valid,
        output retire_trace_t trace,
        input logic trace_ready
    );

    logic has_room;
    logic push;
    fetch_packet_t push_data;
    logic pop;
    logic not_empty;
    fetch_packet_t head;

    fetch_unit fetch_block (
        .clk (clk),
        .rst (rst),
        .has_room (has_room),
        .instr_en (instr_en),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .push (push),
        .push_data (push_data)
    );

    instruction_queue #(.DEPTH(`CORE_QUEUE_DEPTH)) queue_block (
        .clk (clk),
        .rst (rst),
        .push (push),
        .push_data (push_data),
        .has_room (has_room),
        .pop (pop),
        .not_empty (not_empty),
        .head (head)
    );

    execute_unit execute_block (
        .clk (clk),
        .rst (rst),
        .not_empty (not_empty),
        .head (head),
        .pop (pop),
        .trace_valid (trace_valid),
        .trace (trace),
        .trace_ready (trace_ready)
    );

endmodule

// ==== testbench/core_tb.sv ====
// Testbench for the mini RV32I core
// Random program memory with one-cycle reads, a reference register model,
// a retire trace checker under random back-pressure, and a watchdog

`include "core_consts.svh"

module core_tb
    import core_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF = 10;
    localparam int PROG_WORDS = 512;
    localparam int NUM_INSTR = 400;
    localparam int WATCHDOG_NS = NUM_INSTR * 8 * 2 * CLK_HALF + 1000;

    logic clk = 1'b0;
    logic rst;
    logic instr_en;
    logic [`CORE_XLEN-1:0] instr_addr;
    logic [`CORE_XLEN-1:0] instr_data;
    logic trace_valid;
    retire_trace_t trace;
    logic trace_ready;

    logic [`CORE_XLEN-1:0] prog_mem [PROG_WORDS];
    logic [`CORE_XLEN-1:0] ref_regs [`CORE_NUM_REGS];
    logic mem_req;
    logic [`CORE_XLEN-1:0] mem_addr;
    logic [`CORE_XLEN-1:0] exp_pc;
    logic fetch_seen;
    logic hold_pending;
    retire_trace_t held_trace;
    int retired;
    int stall_left;
    int reset_errors;
    int fetch_errors;
    int retire_errors;
    int hold_errors;
    int total_errors;

    mini_core dut0 (
        .clk (clk),
        .rst (rst),
        .instr_en (instr_en),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .trace_valid (trace_valid),
        .trace (trace),
        .trace_ready (trace_ready)
    );

    always #CLK_HALF clk = ~clk;

    //////////////////////////////////////////////////
    // Program generation and reference model

    // Supported ops on x0..x7 plus about 5 % unsupported opcodes
    function automatic logic [31:0] gen_instr();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        int pick;
        rd = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        f3 = 3'($urandom % 8);
        imm = 12'($urandom);
        f7 = 7'h00;
        pick = int'($urandom % 100);
        if (pick < 5) begin
            // Load, store, branch, JAL and AUIPC
            case ($urandom % 5)
                0: return {imm, rs1, f3, rd, 7'b0000011};
                1: return {imm, rs1, f3, rd, 7'b0100011};
                2: return {imm, rs1, f3, rd, 7'b1100011};
                3: return {imm, rs1, f3, rd, 7'b1101111};
                default: return {imm, rs1, f3, rd, 7'b0010111};
            endcase
        end else if (pick < 45) begin
            if ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2 == 1))
                f7 = 7'h20;
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (pick < 90) begin
            if (f3 == 3'b001)
                imm = {7'h00, imm[4:0]};
            else if (f3 == 3'b101)
                imm = {($urandom % 2 == 1) ? 7'h20 : 7'h00, imm[4:0]};
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        return {20'($urandom), rd, 7'b0110111};
    endfunction

    // RV32I funct3 semantics with alt selecting SUB or SRA
    function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
        logic [31:0] shifted;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    shifted = $unsigned($signed(a) >>> b[4:0]);
                else
                    shifted = a >> b[4:0];
                return shifted;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs one instruction in program order on the model registers
    task automatic model_retire(input logic [31:0] ins, output logic wr,
                                output logic [31:0] val);
        logic [2:0] f3;
        logic [6:0] f7;
        logic alt;
        logic ok;
        logic [31:0] a;
        logic [31:0] imm;
        f3 = ins[14:12];
        f7 = ins[31:25];
        alt = (f7 == 7'h20);
        a = ref_regs[ins[19:15]];
        imm = {{20{ins[31]}}, ins[31:20]};
        ok = 1'b0;
        val = '0;
        case (ins[6:0])
            7'b0110011: begin
                ok = (f7 == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
                val = compute_alu(f3, alt, a, ref_regs[ins[24:20]]);
            end
            7'b0010011: begin
                if (f3 == 3'b001)
                    ok = (f7 == 7'h00);
                else if (f3 == 3'b101)
                    ok = (f7 == 7'h00) || alt;
                else
                    ok = 1'b1;
                val = compute_alu(f3, (f3 == 3'b101) && alt, a, imm);
            end
            7'b0110111: begin
                ok = 1'b1;
                val = {ins[31:12], 12'h000};
            end
            default: ok = 1'b0;
        endcase
        wr = ok && (ins[11:7] != 5'd0);
        if (wr)
            ref_regs[ins[11:7]] = val;
    endtask

    //////////////////////////////////////////////////
    // Instruction memory sees the request mid-cycle and answers after the next edge
    always @(negedge clk) begin
        mem_req <= instr_en;
        mem_addr <= instr_addr;
    end

    always @(posedge clk) begin
        #2;
        if (mem_req)
            instr_data = prog_mem[mem_addr[10:2]];
    end

    //////////////////////////////////////////////////
    // Checking helpers
    task automatic report_test(input string name, input int errs);
        $display("Test %s done: %0d errors", name, errs);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h (instruction %0d)", name, got, exp, retired);
            retire_errors++;
        end
    endtask

    task automatic check_retire();
        logic [31:0] exp_instr;
        logic exp_wr;
        logic [31:0] exp_val;
        exp_instr = prog_mem[exp_pc[10:2]];
        model_retire(exp_instr, exp_wr, exp_val);
        compare_field("trace.pc", trace.pc, exp_pc);
        compare_field("trace.instr", trace.instr, exp_instr);
        compare_field("trace.rd", 32'(trace.rd), 32'(exp_instr[11:7]));
        compare_field("trace.wr_en", 32'(trace.wr_en), 32'(exp_wr));
        if (exp_wr)
            compare_field("trace.value", trace.value, exp_val);
        exp_pc = exp_pc + `CORE_PC_STEP;
        retired++;
    endtask

    // Random ready with occasional long stalls to fill the queue
    task automatic drive_ready();
        if (stall_left > 0) begin
            trace_ready = 1'b0;
            stall_left--;
        end else if ($urandom % 32 == 0) begin
            trace_ready = 1'b0;
            stall_left = 4 + int'($urandom % 8);
        end else begin
            trace_ready = ($urandom % 4 != 0);
        end
    endtask

    //////////////////////////////////////////////////
    // Trace monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            if (trace_valid !== 1'b0) begin
                $display("ERROR trace_valid: got %h expected %h in reset", trace_valid, 1'b0);
                reset_errors++;
            end
        end else begin
            if (!fetch_seen && instr_en === 1'b1) begin
                fetch_seen = 1'b1;
                if (instr_addr !== `CORE_RESET_PC) begin
                    $display("ERROR instr_addr: got %h expected %h", instr_addr, `CORE_RESET_PC);
                    fetch_errors++;
                end
                report_test("first_fetch", fetch_errors);
            end
            if (hold_pending) begin
                if (trace_valid !== 1'b1) begin
                    $display("trace_valid dropped while the trace was stalled");
                    hold_errors++;
                end else if (trace !== held_trace) begin
                    $display("ERROR trace: got %h expected %h while stalled", trace, held_trace);
                    hold_errors++;
                end
            end
            hold_pending = trace_valid && !trace_ready;
            held_trace = trace;
            if (trace_valid === 1'b1 && trace_ready && retired < NUM_INSTR)
                check_retire();
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        instr_data = '0;
        trace_ready = 1'b0;
        mem_req = 1'b0;
        mem_addr = '0;
        fetch_seen = 1'b0;
        hold_pending = 1'b0;
        held_trace = '0;
        retired = 0;
        stall_left = 0;
        reset_errors = 0;
        fetch_errors = 0;
        retire_errors = 0;
        hold_errors = 0;
        exp_pc = `CORE_RESET_PC;
        void'($urandom(98));
        for (int i = 0; i < PROG_WORDS; i++)
            prog_mem[i] = gen_instr();
        for (int i = 0; i < `CORE_NUM_REGS; i++)
            ref_regs[i] = '0;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // First cycle out of reset
        @(posedge clk);
        @(negedge clk);
        if (trace_valid !== 1'b0) begin
            $display("ERROR trace_valid: got %h expected %h after reset", trace_valid, 1'b0);
            reset_errors++;
        end
        report_test("reset", reset_errors);

        while (retired < NUM_INSTR) begin
            @(posedge clk);
            #2;
            drive_ready();
        end
        report_test("retire_model", retire_errors);
        report_test("trace_hold", hold_errors);

        total_errors = reset_errors + fetch_errors + retire_errors + hold_errors;
        $display("Tests: 4, retired: %0d, errors: %0d", retired, total_errors);
        if (total_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: only %0d of %0d instructions retired", retired, NUM_INSTR);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/core_pkg.sv
source/register_file.sv
source/alu_unit.sv
source/decode_unit.sv
source/fetch_unit.sv
source/instruction_queue.sv
source/execute_unit.sv
source/mini_core.sv
testbench/core_tb.sv

// ==== Makefile ====
# Verilator build and run for the mini RV32I core testbench

VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= Finished with no errors

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := source/core_consts.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
